// File: verilog/fetch_pkg.sv
package fetch_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int PC_W      = 32;
    localparam int INSTR_W   = 32;
    // rom of 1024 words
    localparam int MEM_IDX_W = 10;

    typedef logic [PC_W-1:0]      pc_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [MEM_IDX_W-1:0] mem_idx_t;

    // pc register after reset, first fetch lands on 0
    localparam pc_t RESET_PC = 32'hffff_fffc;

    // one-hot, as in the older fetch stage
    typedef enum logic [2:0] {
        LEAP  = 3'b001,
        EMPTY = 3'b010,
        FULL  = 3'b100
    } fetch_state_e;

    // one fetched instruction on its way to decode
    typedef struct packed {
        pc_t    pc;
        instr_t instr;
    } if_to_id_t;

    // rom contents, inverted index on top and plain index below
    function automatic instr_t rom_word(input mem_idx_t idx);
        logic [15:0] w;
        w = 16'(idx);
        return {~w, w};
    endfunction

endpackage

// File: verilog/pc_gen.sv
module pc_gen import fetch_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic redirect,
    input  pc_t  redirect_pc,
    input  logic if_allow_in,
    output logic pre_valid,
    output logic pre_ready_go,
    output pc_t  next_pc
);

    pc_t  last_pc;
    logic redir_pend;
    pc_t  redir_tgt;
    logic accept;

    // request taken by the fetch stage this edge
    assign accept = pre_valid && pre_ready_go && if_allow_in;

    // address formed in the same cycle so no stall here
    assign pre_ready_go = 1'b1;
    // a next address is always on offer
    assign pre_valid    = 1'b1;

    ////////////////////
    // next address
    ////////////////////
    // fresh redirect wins over the remembered one and over plus four
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (redir_pend) begin
            next_pc = redir_tgt;
        end else begin
            next_pc = last_pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_pc    <= RESET_PC;
            redir_pend <= 1'b0;
        end else begin
            if (accept) begin
                last_pc <= next_pc;
            end
            // issued target clears the pending flag
            if (accept) begin
                redir_pend <= 1'b0;
            end else if (redirect) begin
                redir_pend <= 1'b1;
            end
        end
    end

    // target held until the fetch stage takes it
    always_ff @(posedge clk) begin
        if (redirect && !accept) begin
            redir_tgt <= redirect_pc;
        end
    end

    // remembered redirect goes out with the very next accepted request
    a_pend_issued : assert property (@(posedge clk) disable iff (!rst_n)
        (redir_pend && accept && !redirect) |=> (!redir_pend && last_pc == $past(redir_tgt)));

endmodule

// File: verilog/inst_mem.sv
module inst_mem import fetch_pkg::*; #(
    parameter int MEM_LATENCY = 2,
    parameter int ROM_AW      = 10
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   req,
    input  pc_t    addr,
    output logic   data_ok,
    output instr_t rdata
);

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    instr_t             rom [0:(1 << ROM_AW) - 1];
    logic [ROM_AW-1:0]  idx_q;
    logic [CNT_W-1:0]   cnt;

    ////////////////////
    // rom image
    ////////////////////
    initial begin
        for (int i = 0; i < (1 << ROM_AW); i++) begin
            rom[i] = rom_word(mem_idx_t'(i));
        end
    end

    // word index, byte offset dropped
    always_ff @(posedge clk) begin
        if (req) begin
            idx_q <= addr[ROM_AW+1:2];
        end
    end

    ////////////////////
    // reply timer
    ////////////////////
    // zero means idle, one means reply now
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (req) begin
            cnt <= CNT_W'(MEM_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign data_ok = (cnt == CNT_W'(1));
    // only meaningful with data_ok
    assign rdata   = rom[idx_q];

    // fetch stage must not ask again while a reply is owed
    a_one_outstanding : assert property (@(posedge clk) disable iff (!rst_n)
        req |-> (cnt == '0 || data_ok));

endmodule

// File: verilog/fetch_stage.sv
module fetch_stage import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      hold,
    input  logic      cancel,
    input  logic      mem_data_ok,
    input  instr_t    rom_rdata,
    input  pc_t       next_pc,
    input  logic      pre_valid,
    input  logic      pre_ready_go,
    input  logic      id_allow_in,
    output logic      if_allow_in,
    output logic      if_valid,
    output logic      if_ready_go,
    output if_to_id_t if_bundle
);

    fetch_state_e state;
    fetch_state_e state_nxt;
    pc_t          pc_q;
    // instruction parked while decode is busy
    logic         inst_buf_vld;
    instr_t       inst_buf;
    logic         pipe_valid;
    logic         req_ok;
    logic         commit_ok;
    logic         have_reply;

    ////////////////////
    // handshake
    ////////////////////
    assign pipe_valid = pre_valid && pre_ready_go;
    assign req_ok     = pipe_valid && if_allow_in;
    assign commit_ok  = if_ready_go && id_allow_in;
    // reply in hand, parked or arriving now
    assign have_reply = mem_data_ok || inst_buf_vld;

    assign if_valid    = (state == FULL);
    assign if_ready_go = if_valid && have_reply && !hold;
    // empty, or the held item leaves this edge
    // no refill on a flush edge, the target comes next
    assign if_allow_in = (state == EMPTY) || (commit_ok && !cancel);

    assign if_bundle.pc    = pc_q;
    assign if_bundle.instr = inst_buf_vld ? inst_buf : rom_rdata;

    ////////////////////
    // state machine
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            // orphan reply still on its way
            LEAP: begin
                if (mem_data_ok) begin
                    state_nxt = EMPTY;
                end
            end
            EMPTY: begin
                if (req_ok) begin
                    state_nxt = FULL;
                end
            end
            FULL: begin
                if (cancel) begin
                    // nothing owed once the reply is in
                    state_nxt = have_reply ? EMPTY : LEAP;
                end else if (commit_ok) begin
                    // back to back when a new pc is taken
                    state_nxt = req_ok ? FULL : EMPTY;
                end
            end
            default: begin
                state_nxt = EMPTY;
            end
        endcase
    end

    ////////////////////
    // pc and side buffer
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (req_ok) begin
            pc_q <= next_pc;
        end
    end

    // reply during a stall is kept here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_buf_vld <= 1'b0;
        end else if (cancel || commit_ok) begin
            inst_buf_vld <= 1'b0;
        end else if (mem_data_ok && state == FULL) begin
            inst_buf_vld <= 1'b1;
        end
    end

    // late reply in LEAP never lands here
    always_ff @(posedge clk) begin
        if (mem_data_ok && state == FULL && !commit_ok) begin
            inst_buf <= rom_rdata;
        end
    end

    ////////////////////
    // checks
    ////////////////////
    a_go_needs_valid : assert property (@(posedge clk) disable iff (!rst_n)
        if_ready_go |-> if_valid);

    // a reply in EMPTY would mean memory and stage disagree on what is owed
    a_no_reply_empty : assert property (@(posedge clk) disable iff (!rst_n)
        mem_data_ok |-> (state != EMPTY));

endmodule

// File: verilog/decode_latch.sv
module decode_latch import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      if_valid,
    input  logic      if_ready_go,
    input  if_to_id_t if_bundle,
    input  logic      id_ready,
    output logic      id_allow_in,
    output logic      id_valid,
    output if_to_id_t id_bundle
);

    logic      valid_q;
    if_to_id_t bundle_q;
    logic      load;
    logic      consume;

    ////////////////////
    // handshake
    ////////////////////
    assign load    = if_valid && if_ready_go && id_allow_in;
    assign consume = valid_q && id_ready;

    // room when empty or when the item leaves this edge
    assign id_allow_in = !valid_q || id_ready;

    assign id_valid  = valid_q;
    assign id_bundle = bundle_q;

    // flush beats a refill, the item came from the old path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (consume) begin
            valid_q <= 1'b0;
        end
    end

    // pc and instruction, no reset
    always_ff @(posedge clk) begin
        if (load) begin
            bundle_q <= if_bundle;
        end
    end

    // back-pressure keeps the output still
    a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (id_valid && !id_ready && !flush) |=> (id_valid && $stable(id_bundle)));

endmodule

// File: verilog/fetch_top.sv
module fetch_top import fetch_pkg::*; #(
    parameter int MEM_LATENCY = 2,
    parameter int ROM_AW      = MEM_IDX_W
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      redirect,
    input  pc_t       redirect_pc,
    input  logic      hold,
    input  logic      id_ready,
    output logic      id_valid,
    output if_to_id_t id_bundle
);

    // pre stage to fetch
    logic      pre_valid;
    logic      pre_ready_go;
    pc_t       next_pc;
    logic      if_allow_in;
    // memory
    logic      mem_req;
    logic      mem_data_ok;
    instr_t    rom_rdata;
    // fetch to decode
    logic      if_valid;
    logic      if_ready_go;
    if_to_id_t if_bundle;
    logic      id_allow_in;

    // request goes out on the edge the fetch stage takes the pc
    assign mem_req = pre_valid && pre_ready_go && if_allow_in;

    pc_gen u_pc_gen (
        .clk, .rst_n, .redirect, .redirect_pc, .if_allow_in,
        .pre_valid, .pre_ready_go, .next_pc
    );

    inst_mem #(
        .MEM_LATENCY (MEM_LATENCY),
        .ROM_AW      (ROM_AW)
    ) u_inst_mem (
        .clk, .rst_n, .req(mem_req), .addr(next_pc),
        .data_ok(mem_data_ok), .rdata(rom_rdata)
    );

    // redirect cancels the held fetch
    fetch_stage u_fetch_stage (
        .clk, .rst_n, .hold, .cancel(redirect), .mem_data_ok, .rom_rdata,
        .next_pc, .pre_valid, .pre_ready_go, .id_allow_in,
        .if_allow_in, .if_valid, .if_ready_go, .if_bundle
    );

    decode_latch u_decode_latch (
        .clk, .rst_n, .flush(redirect), .if_valid, .if_ready_go, .if_bundle,
        .id_ready, .id_allow_in, .id_valid, .id_bundle
    );

endmodule

// File: verification/fetch_tb_table.svh
// columns: cycles, redirect mode, redirect target, hold mode, id_ready mode
// redirect M_HIGH fires once at the row start, M_RAND fires now and then
localparam int ROW_N = 12;

localparam row_t ROWS [ROW_N] = '{
    // first items after reset
    '{12,  M_LOW,  32'h0000_0000, M_LOW,   M_HIGH},
    // steady stream
    '{20,  M_LOW,  32'h0000_0000, M_LOW,   M_HIGH},
    // consumer stalled, then released
    '{10,  M_LOW,  32'h0000_0000, M_LOW,   M_LOW },
    '{12,  M_LOW,  32'h0000_0000, M_LOW,   M_HIGH},
    // hold lands on reply cycles, side buffer in use
    '{30,  M_LOW,  32'h0000_0000, M_PULSE, M_HIGH},
    '{24,  M_LOW,  32'h0000_0000, M_PULSE, M_PULSE},
    // redirects at mixed reply phases
    '{9,   M_HIGH, 32'h0000_0100, M_LOW,   M_HIGH},
    '{10,  M_HIGH, 32'h0000_03f0, M_LOW,   M_HIGH},
    // rom index wraps past 0xffc
    '{11,  M_HIGH, 32'h0000_0ff8, M_LOW,   M_HIGH},
    // flush while the output is stalled
    '{8,   M_HIGH, 32'h0000_0040, M_LOW,   M_LOW },
    '{12,  M_HIGH, 32'h0000_0204, M_PULSE, M_HIGH},
    // long random mix
    '{400, M_RAND, 32'h0000_0000, M_RAND,  M_RAND}
};

// File: verification/fetch_tb.sv
module fetch_tb import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 5;

    typedef enum logic [1:0] {M_LOW, M_HIGH, M_PULSE, M_RAND} drive_mode_e;

    typedef struct packed {
        int          cycles;
        drive_mode_e redir_mode;
        pc_t         target;
        drive_mode_e hold_mode;
        drive_mode_e ready_mode;
    } row_t;

    `include "fetch_tb_table.svh"

    logic      clk;
    logic      rst_n;
    logic      redirect;
    pc_t       redirect_pc;
    logic      hold;
    logic      id_ready;
    logic      id_valid;
    if_to_id_t id_bundle;

    integer    seed;
    int        checks;
    int        errors;
    int        row_items;
    // reference model of the pc stream
    pc_t       exp_pc;
    // output and inputs as they stood across the last edge
    logic      prev_valid;
    logic      prev_ready;
    logic      prev_redirect;
    if_to_id_t prev_bundle;

    fetch_top #(
        .MEM_LATENCY (2)
    ) UUT (
        .clk, .rst_n, .redirect, .redirect_pc, .hold, .id_ready,
        .id_valid, .id_bundle
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////
    // rom rule with the inverted word index over the plain one
    function automatic instr_t word_at(input pc_t pc);
        logic [15:0] idx;
        idx = {6'b0, pc[11:2]};
        return {~idx, idx};
    endfunction

    function automatic logic pick_level(input drive_mode_e mode, input int cyc,
                                        input logic coin);
        case (mode)
            M_LOW:   return 1'b0;
            M_HIGH:  return 1'b1;
            // high every third cycle
            M_PULSE: return (cyc % 3 == 1);
            default: return coin;
        endcase
    endfunction

    function automatic int total_cycles();
        int sum;
        sum = 0;
        foreach (ROWS[i]) begin
            sum += ROWS[i].cycles;
        end
        return sum;
    endfunction

    ////////////////////
    // stimulus and checks
    ////////////////////
    initial begin
        int          r;
        int          c;
        int          err_start;
        logic [31:0] rnd;
        row_t        row;
        seed          = 32'hefa3_5cab;
        checks        = 0;
        errors        = 0;
        rst_n         = 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        hold          = 1'b0;
        id_ready      = 1'b0;
        exp_pc        = '0;
        prev_valid    = 1'b0;
        prev_ready    = 1'b0;
        prev_redirect = 1'b0;
        prev_bundle   = '0;
        // output idle through reset
        repeat (RST_CYCLES) begin
            @(posedge clk);
            #2;
            checks++;
            if (id_valid !== 1'b0) begin
                $display("CHECK FAILED reset: id_valid got %h expected 0", id_valid);
                errors++;
            end
        end
        rst_n = 1'b1;
        for (r = 0; r < ROW_N; r++) begin
            row       = ROWS[r];
            row_items = 0;
            err_start = errors;
            for (c = 0; c < row.cycles; c++) begin
                @(posedge clk);
                #2;
                // stalled output must not move
                if (prev_valid && !prev_ready && !prev_redirect) begin
                    checks += 2;
                    if (id_valid !== 1'b1) begin
                        $display("CHECK FAILED row %0d: id_valid got %h expected 1",
                                 r, id_valid);
                        errors++;
                    end
                    if (id_bundle !== prev_bundle) begin
                        $display("CHECK FAILED row %0d: id_bundle got %h expected %h",
                                 r, id_bundle, prev_bundle);
                        errors++;
                    end
                end
                rnd = $random(seed);
                if (row.redir_mode == M_RAND) begin
                    // one-cycle pulses only
                    redirect    = (rnd[7:4] == 4'h0) && !redirect;
                    redirect_pc = {20'h0, rnd[17:8], 2'b00};
                end else begin
                    redirect    = (row.redir_mode == M_HIGH) && (c == 0);
                    redirect_pc = row.target;
                end
                hold     = pick_level(row.hold_mode, c, rnd[1:0] == 2'b00);
                id_ready = pick_level(row.ready_mode, c, rnd[3:2] != 2'b00);
                // item leaves on the coming edge
                if (id_valid === 1'b1 && id_ready) begin
                    row_items++;
                    checks += 2;
                    if (id_bundle.pc !== exp_pc) begin
                        $display("CHECK FAILED row %0d: id_bundle.pc got %h expected %h",
                                 r, id_bundle.pc, exp_pc);
                        errors++;
                    end
                    if (id_bundle.instr !== word_at(exp_pc)) begin
                        $display("CHECK FAILED row %0d: id_bundle.instr got %h expected %h",
                                 r, id_bundle.instr, word_at(exp_pc));
                        errors++;
                    end
                    exp_pc = exp_pc + 32'd4;
                end
                // redirect edge restarts the stream at the target
                if (redirect) begin
                    exp_pc = redirect_pc;
                end
                prev_valid    = id_valid;
                prev_ready    = id_ready;
                prev_redirect = redirect;
                prev_bundle   = id_bundle;
            end
            if (row.ready_mode != M_LOW && row_items == 0) begin
                $display("row %0d: no instruction reached the output", r);
                errors++;
            end
            $display("row %0d: %0d cycles, %0d items, %0d errors",
                     r, row.cycles, row_items, errors - err_start);
        end
        $display("summary: %0d rows, %0d checks, %0d errors", ROW_N, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // run length from the table plus some slack
    initial begin
        int limit_cycles;
        limit_cycles = RST_CYCLES + total_cycles() + 50;
        #(limit_cycles * CLK_PERIOD);
        $display("watchdog: run timed out after %0d cycles", limit_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+verification
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/inst_mem.sv
verilog/fetch_stage.sv
verilog/decode_latch.sv
verilog/fetch_top.sv
verification/fetch_tb.sv
